// ==== common/mclPkg.sv ====
package mclPkg;

  localparam int memFuncWidth = 4;
  localparam int magicWidth = 9;
  localparam int adWidth = 13;
  localparam int diagSliceWidth = 6;

  // Microword memory function field
  typedef enum logic [memFuncWidth-1:0] {
    funcNone        = 4'd0,
    funcLoadAr      = 4'd1,
    funcLoadArx     = 4'd2,
    funcRwCycle     = 4'd3,
    funcRpwCycle    = 4'd4,
    funcWrite       = 4'd5,
    funcUncondFetch = 4'd6,
    funcCondFetch   = 4'd7,
    funcEaCalc      = 4'd8,
    funcAdFunc      = 4'd9,
    funcRegFunc     = 4'd10
  } memFuncE;

  typedef struct packed {
    logic loadAr;
    logic loadArx;
    logic pause;
    logic write;
  } cycleBitsT;

  // Magic field as seen by EA calculation
  typedef struct packed {
    cycleBitsT  cycle;
    logic       prevCtx;
    logic       extendEa;
    logic [2:0] spare;
  } eaMagicT;

  // Magic field as seen by fetch and AD function cycles
  typedef struct packed {
    logic       skipEn;
    logic       fetchForce;
    logic       cacheInhibit;
    logic [5:0] spare;
  } fetchMagicT;

  typedef union packed {
    eaMagicT    eaView;
    fetchMagicT fetchView;
  } magicU;

  typedef struct packed {
    memFuncE memFunc;
    magicU   magic;
  } microwordT;

  typedef struct packed {
    logic isEaCalc;
    logic isAdFunc;
    logic isRegFunc;
    logic isCondFetch;
    logic isUncondFetch;
    logic isRequest;
  } funcFlagsT;

  typedef struct packed {
    logic user;
    logic public;
    logic previous;
    logic extended;
  } vmaCtxT;

  typedef struct packed {
    logic cry0;
    logic cry1;
    logic fov;
    logic fpd;
    logic userMode;
    logic userIot;
    logic publicMode;
    logic adrBrkInh;
    logic trapReq2;
    logic trapReq1;
    logic fxu;
    logic pcSection0;
  } pcFlagsT;

  // Same width as pcFlagsT so either can drive heldOrPc
  typedef struct packed {
    cycleBitsT cycle;
    vmaCtxT    ctx;
    logic      fetch;
    logic      regFunc;
    logic      cacheInhibit;
    logic      addrErr;
  } heldT;

  typedef struct packed {
    logic [2:0] readSel;
    logic       readEn;
    logic       forceExtend;
  } diagCfgT;

endpackage

// ==== hw/memFuncDecode.sv ====
`timescale 1ns/1ps

module memFuncDecode (
  input  mclPkg::microwordT          microword,
  input  logic [0:mclPkg::adWidth-1] ad,
  input  logic                       testSatisfied,
  output mclPkg::funcFlagsT          flags,
  output mclPkg::cycleBitsT          nextCycle
);

  logic condMet;

  // Conditional fetch only goes when the skip is armed
  assign condMet = microword.magic.fetchView.skipEn & testSatisfied;

  always_comb begin
    flags = '0;
    nextCycle = '0;
    flags.isRequest = 1'b1;

    case (microword.memFunc)
      mclPkg::funcNone: begin
        flags.isRequest = 1'b0;
      end
      mclPkg::funcLoadAr: begin
        nextCycle.loadAr = 1'b1;
      end
      mclPkg::funcLoadArx: begin
        nextCycle.loadArx = 1'b1;
      end
      mclPkg::funcRwCycle: begin
        nextCycle.loadAr = 1'b1;
        nextCycle.write = 1'b1;
      end
      mclPkg::funcRpwCycle: begin
        nextCycle.loadAr = 1'b1;
        nextCycle.pause = 1'b1;
        nextCycle.write = 1'b1;
      end
      mclPkg::funcWrite: begin
        nextCycle.write = 1'b1;
      end
      mclPkg::funcUncondFetch: begin
        flags.isUncondFetch = 1'b1;
        nextCycle.loadArx = 1'b1;
      end
      mclPkg::funcCondFetch: begin
        flags.isCondFetch = 1'b1;
        flags.isRequest = condMet;
        nextCycle.loadArx = condMet;
      end
      mclPkg::funcEaCalc: begin
        flags.isEaCalc = 1'b1;
        nextCycle = microword.magic.eaView.cycle;
      end
      mclPkg::funcAdFunc: begin
        flags.isAdFunc = 1'b1;
        // AD bits 1-4 carry the cycle type
        nextCycle = mclPkg::cycleBitsT'(ad[1:4]);
      end
      mclPkg::funcRegFunc: begin
        flags.isRegFunc = 1'b1;
      end
      default: begin
        flags.isRequest = 1'b0;
      end
    endcase
  end

endmodule

// ==== cycleCtl/memCycleCtl.sv ====
`timescale 1ns/1ps

module memCycleCtl (
  input  logic                                 clk,
  input  logic                                 reset,
  input  mclPkg::funcFlagsT                    flags,
  input  mclPkg::cycleBitsT                    nextCycle,
  input  logic                                 fetchForce,
  input  logic                                 cacheInhibit,
  input  mclPkg::vmaCtxT                       vmaCtx,
  input  logic                                 addrErr,
  input  logic                                 loadHeld,
  input  logic                                 condSelVma,
  input  mclPkg::pcFlagsT                      pcFlags,
  output mclPkg::cycleBitsT                    cycle,
  output logic                                 fetch,
  output logic                                 storeAr,
  output logic                                 mboxReq,
  output logic [0:$bits(mclPkg::pcFlagsT)-1]   heldOrPc
);

  logic        fetchNext;
  logic        regFuncReg;
  logic        cacheInhibitReg;
  mclPkg::heldT heldReg;

  // The fetch magic bits mean nothing in an EA calculation
  assign fetchNext = flags.isUncondFetch | flags.isCondFetch |
                     (fetchForce & ~flags.isEaCalc);

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle <= '0;
      fetch <= 1'b0;
      regFuncReg <= 1'b0;
      cacheInhibitReg <= 1'b0;
      mboxReq <= 1'b0;
    end else begin
      mboxReq <= flags.isRequest;
      if (flags.isRequest) begin
        cycle <= nextCycle;
        fetch <= fetchNext;
        regFuncReg <= flags.isRegFunc;
        cacheInhibitReg <= cacheInhibit & ~flags.isEaCalc;
      end
    end
  end

  // Pure write-back half of a read-pause-write
  assign storeAr = cycle.pause & cycle.write & ~cycle.loadAr & ~cycle.loadArx;

  always_ff @(posedge clk) begin
    if (reset) begin
      heldReg <= '0;
    end else if (loadHeld) begin
      heldReg.cycle <= cycle;
      heldReg.ctx <= vmaCtx;
      heldReg.fetch <= fetch;
      heldReg.regFunc <= regFuncReg;
      heldReg.cacheInhibit <= cacheInhibitReg;
      heldReg.addrErr <= addrErr;
    end
  end

  // Conditional microcode sees either the held state or the PC flags
  assign heldOrPc = condSelVma ? heldReg : pcFlags;

endmodule

// ==== vmaContext/vmaContext.sv ====
`timescale 1ns/1ps

module vmaContext (
  input  logic                       clk,
  input  logic                       reset,
  input  mclPkg::funcFlagsT          flags,
  input  mclPkg::magicU              magic,
  input  logic [0:mclPkg::adWidth-1] ad,
  input  mclPkg::pcFlagsT            pcFlags,
  input  logic                       loadVmaContext,
  input  logic                       forceExtend,
  output mclPkg::vmaCtxT             vmaCtx,
  output logic                       addrErr
);

  mclPkg::vmaCtxT ctxNext;
  mclPkg::vmaCtxT ctxReg;
  logic           regFuncReg;
  logic           addrErrNext;

  always_comb begin
    ctxNext.previous = flags.isEaCalc & magic.eaView.prevCtx;

    // AD function supplies its own user and public bits
    if (flags.isAdFunc) begin
      ctxNext.user = ad[5];
      ctxNext.public = ad[6];
    end else begin
      ctxNext.user = pcFlags.userMode;
      ctxNext.public = pcFlags.publicMode;
    end

    // No extended reference out of section 0
    ctxNext.extended = ((flags.isEaCalc & magic.eaView.extendEa) | forceExtend) &
                       ~pcFlags.pcSection0;
  end

  // Extended address must not carry section bits in AD 6-11
  assign addrErrNext = ctxNext.extended & (ad[6:11] != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      ctxReg <= '0;
      regFuncReg <= 1'b0;
      addrErr <= 1'b0;
    end else if (loadVmaContext) begin
      ctxReg <= ctxNext;
      regFuncReg <= flags.isRegFunc;
      addrErr <= addrErrNext;
    end
  end

  // Register functions run with no user/public/previous context
  always_comb begin
    vmaCtx.user = ctxReg.user & ~regFuncReg;
    vmaCtx.public = ctxReg.public & ~regFuncReg;
    vmaCtx.previous = ctxReg.previous & ~regFuncReg;
    vmaCtx.extended = ctxReg.extended;
  end

endmodule

// ==== hw/diagRegs.sv ====
`timescale 1ns/1ps

module diagRegs #(
  parameter logic [3:0] diagAddr = 4'hA
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic                                  diagWrite,
  input  logic [3:0]                            diagRegAddr,
  input  logic [$bits(mclPkg::diagCfgT)-1:0]    diagData,
  output mclPkg::diagCfgT                       cfg
);

  logic addrHit;

  assign addrHit = diagRegAddr == diagAddr;

  // Written only when the diag strobe hits our address
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg <= '0;
    end else if (diagWrite && addrHit) begin
      cfg <= mclPkg::diagCfgT'(diagData);
    end
  end

endmodule

// ==== hw/diagReadback.sv ====
`timescale 1ns/1ps

module diagReadback (
  input  mclPkg::diagCfgT                      cfg,
  input  mclPkg::cycleBitsT                    cycle,
  input  logic                                 fetch,
  input  logic                                 storeAr,
  input  logic                                 mboxReq,
  input  mclPkg::vmaCtxT                       vmaCtx,
  input  logic                                 addrErr,
  input  logic [0:$bits(mclPkg::pcFlagsT)-1]   heldOrPc,
  output logic [mclPkg::diagSliceWidth-1:0]    diagBus
);

  logic [mclPkg::diagSliceWidth-1:0] word;

  always_comb begin
    case (cfg.readSel)
      3'd0: begin
        word = {cycle, fetch, storeAr};
      end
      3'd1: begin
        word = {vmaCtx, addrErr, mboxReq};
      end
      3'd2: begin
        word = heldOrPc[0:5];
      end
      3'd3: begin
        word = heldOrPc[6:11];
      end
      // Upper selects are unused
      default: begin
        word = '0;
      end
    endcase
  end

  // Bus slice floats low when not reading
  assign diagBus = cfg.readEn ? word : '0;

endmodule

// ==== hw/mcl.sv ====
`timescale 1ns/1ps

module mcl #(
  parameter logic [3:0] diagAddr = 4'hA
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  mclPkg::microwordT                    microword,
  input  logic [0:mclPkg::adWidth-1]           ad,
  input  mclPkg::pcFlagsT                      pcFlags,
  input  logic                                 testSatisfied,
  input  logic                                 loadVmaContext,
  input  logic                                 loadHeld,
  input  logic                                 condSelVma,
  input  logic                                 diagWrite,
  input  logic [3:0]                           diagRegAddr,
  input  logic [$bits(mclPkg::diagCfgT)-1:0]   diagData,
  output mclPkg::cycleBitsT                    cycle,
  output logic                                 fetch,
  output logic                                 storeAr,
  output logic                                 mboxReq,
  output mclPkg::vmaCtxT                       vmaCtx,
  output logic                                 addrErr,
  output logic [0:$bits(mclPkg::pcFlagsT)-1]   heldOrPc,
  output logic [mclPkg::diagSliceWidth-1:0]    diagBus
);

  mclPkg::funcFlagsT flags;
  mclPkg::cycleBitsT nextCycle;
  mclPkg::diagCfgT   diagCfg;

  memFuncDecode decode (
    .microword(microword),
    .ad(ad),
    .testSatisfied(testSatisfied),
    .flags(flags),
    .nextCycle(nextCycle)
  );

  memCycleCtl cycleCtl (
    .clk(clk),
    .reset(reset),
    .flags(flags),
    .nextCycle(nextCycle),
    .fetchForce(microword.magic.fetchView.fetchForce),
    .cacheInhibit(microword.magic.fetchView.cacheInhibit),
    .vmaCtx(vmaCtx),
    .addrErr(addrErr),
    .loadHeld(loadHeld),
    .condSelVma(condSelVma),
    .pcFlags(pcFlags),
    .cycle(cycle),
    .fetch(fetch),
    .storeAr(storeAr),
    .mboxReq(mboxReq),
    .heldOrPc(heldOrPc)
  );

  vmaContext ctxRegs (
    .clk(clk),
    .reset(reset),
    .flags(flags),
    .magic(microword.magic),
    .ad(ad),
    .pcFlags(pcFlags),
    .loadVmaContext(loadVmaContext),
    .forceExtend(diagCfg.forceExtend),
    .vmaCtx(vmaCtx),
    .addrErr(addrErr)
  );

  diagRegs #(
    .diagAddr(diagAddr)
  ) diagCfgReg (
    .clk(clk),
    .reset(reset),
    .diagWrite(diagWrite),
    .diagRegAddr(diagRegAddr),
    .diagData(diagData),
    .cfg(diagCfg)
  );

  diagReadback readback (
    .cfg(diagCfg),
    .cycle(cycle),
    .fetch(fetch),
    .storeAr(storeAr),
    .mboxReq(mboxReq),
    .vmaCtx(vmaCtx),
    .addrErr(addrErr),
    .heldOrPc(heldOrPc),
    .diagBus(diagBus)
  );

endmodule

// ==== verification/mclVectors.svh ====
// Each row holds func, magic, ad, {randAd, testSatisfied}, pcFlags,
// {loadVmaContext, loadHeld, condSelVma, diagWrite}, diagRegAddr, diagData,
// then expected cycle, {fetch, storeAr, mboxReq}, vmaCtx, addrErr, heldOrPc, diagBus
typedef struct packed {
  logic [3:0]  memFunc;
  logic [8:0]  magic;
  logic [12:0] ad;
  logic [1:0]  ctl;
  logic [11:0] pcFlags;
  logic [3:0]  strobes;
  logic [3:0]  diagRegAddr;
  logic [4:0]  diagData;
  logic [3:0]  expCycle;
  logic [2:0]  expBits;
  logic [3:0]  expCtx;
  logic        expAddrErr;
  logic [11:0] expHeld;
  logic [5:0]  expDiag;
} vecT;

localparam int numVecs = 41;

localparam vecT vectors [numVecs] = '{
  '{4'h0,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h0,3'b000,4'h0,1'b0,12'h000,6'h00},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h8,3'b001,4'h0,1'b0,12'h000,6'h00},
  '{4'h2,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h4,3'b001,4'h0,1'b0,12'h000,6'h00},
  '{4'h3,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h9,3'b001,4'h0,1'b0,12'h000,6'h00},
  '{4'h4,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'hB,3'b001,4'h0,1'b0,12'h000,6'h00},
  '{4'h5,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h1,3'b001,4'h0,1'b0,12'h000,6'h00},
  // EA calculation with pause and write gives the store half of RPW
  '{4'h8,9'h060,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h3,3'b011,4'h0,1'b0,12'h000,6'h00},
  '{4'h6,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h4,3'b101,4'h0,1'b0,12'h000,6'h00},
  '{4'h9,9'h000,13'h0A00,2'b00,12'h000,4'b0000,4'h0,5'h00,4'hA,3'b001,4'h0,1'b0,12'h000,6'h00},
  '{4'hA,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h0,3'b001,4'h0,1'b0,12'h000,6'h00},
  '{4'h0,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h0,3'b000,4'h0,1'b0,12'h000,6'h00},
  // Fetch forced from the magic field
  '{4'h2,9'h080,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h4,3'b101,4'h0,1'b0,12'h000,6'h00},
  // Conditional fetch
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h8,3'b001,4'h0,1'b0,12'h000,6'h00},
  '{4'h7,9'h100,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h8,3'b000,4'h0,1'b0,12'h000,6'h00},
  '{4'h7,9'h000,13'h0000,2'b11,12'h000,4'b0000,4'h0,5'h00,4'h8,3'b000,4'h0,1'b0,12'h000,6'h00},
  '{4'h7,9'h100,13'h0000,2'b11,12'h000,4'b0000,4'h0,5'h00,4'h4,3'b101,4'h0,1'b0,12'h000,6'h00},
  '{4'h0,9'h000,13'h0000,2'b10,12'h000,4'b0000,4'h0,5'h00,4'h4,3'b100,4'h0,1'b0,12'h000,6'h00},
  // Context loads and address error
  '{4'h0,9'h000,13'h0000,2'b00,12'h0A0,4'b1000,4'h0,5'h00,4'h4,3'b100,4'hC,1'b0,12'h0A0,6'h00},
  '{4'h8,9'h018,13'h0000,2'b00,12'h000,4'b1000,4'h0,5'h00,4'h0,3'b001,4'h3,1'b0,12'h000,6'h00},
  '{4'h8,9'h018,13'h0008,2'b00,12'h000,4'b1000,4'h0,5'h00,4'h0,3'b001,4'h3,1'b1,12'h000,6'h00},
  '{4'h8,9'h018,13'h0008,2'b00,12'h001,4'b1000,4'h0,5'h00,4'h0,3'b001,4'h2,1'b0,12'h001,6'h00},
  '{4'h9,9'h000,13'h0480,2'b00,12'h0A0,4'b1000,4'h0,5'h00,4'h4,3'b001,4'h8,1'b0,12'h0A0,6'h00},
  '{4'h9,9'h000,13'h0040,2'b00,12'h0A0,4'b1000,4'h0,5'h00,4'h0,3'b001,4'h4,1'b0,12'h0A0,6'h00},
  '{4'hA,9'h000,13'h0000,2'b00,12'h0A0,4'b1000,4'h0,5'h00,4'h0,3'b001,4'h0,1'b0,12'h0A0,6'h00},
  // Force extend on, then off again
  '{4'h0,9'h000,13'h0000,2'b00,12'h000,4'b0001,4'h5,5'h01,4'h0,3'b000,4'h0,1'b0,12'h000,6'h00},
  '{4'h0,9'h000,13'h0002,2'b00,12'h000,4'b1000,4'h0,5'h00,4'h0,3'b000,4'h1,1'b1,12'h000,6'h00},
  '{4'h0,9'h000,13'h0000,2'b00,12'h001,4'b1001,4'h5,5'h00,4'h0,3'b000,4'h0,1'b0,12'h001,6'h00},
  // Held state capture
  '{4'h6,9'h040,13'h0000,2'b00,12'h080,4'b1000,4'h0,5'h00,4'h4,3'b101,4'h8,1'b0,12'h080,6'h00},
  '{4'h0,9'h000,13'h0000,2'b00,12'h080,4'b0100,4'h0,5'h00,4'h4,3'b100,4'h8,1'b0,12'h080,6'h00},
  '{4'h0,9'h000,13'h0000,2'b10,12'h555,4'b0010,4'h0,5'h00,4'h4,3'b100,4'h8,1'b0,12'h48A,6'h00},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0010,4'h0,5'h00,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h00},
  // Diagnostic readback after a write that misses the address
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h3,5'h02,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h00},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h5,5'h02,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h20},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h5,5'h06,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h21},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h5,5'h0A,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h12},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h5,5'h0E,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h0A},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h5,5'h12,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h00},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h5,5'h16,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h00},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h5,5'h1A,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h00},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h5,5'h1E,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h00},
  '{4'h1,9'h000,13'h0000,2'b10,12'h000,4'b0011,4'h5,5'h00,4'h8,3'b001,4'h8,1'b0,12'h48A,6'h00}
};

// ==== verification/mclTb.sv ====
`timescale 1ns/1ps

module mclTb;

  `include "mclVectors.svh"

  localparam int edgeTimeout = 100;

  logic clk = 1'b0;
  logic reset;
  mclPkg::microwordT microword;
  logic [0:mclPkg::adWidth-1] ad;
  mclPkg::pcFlagsT pcFlags;
  logic testSatisfied;
  logic loadVmaContext;
  logic loadHeld;
  logic condSelVma;
  logic diagWrite;
  logic [3:0] diagRegAddr;
  logic [4:0] diagData;
  mclPkg::cycleBitsT cycle;
  logic fetch;
  logic storeAr;
  logic mboxReq;
  mclPkg::vmaCtxT vmaCtx;
  logic addrErr;
  logic [0:11] heldOrPc;
  logic [5:0] diagBus;

  int edgeCount = 0;
  int passCount = 0;
  int failCount = 0;
  int rowErrors = 0;
  logic timedOut = 1'b0;
  logic [31:0] lfsrState = 32'h2359;

  mcl #(
    .diagAddr(4'h5)
  ) UUT (
    .clk(clk),
    .reset(reset),
    .microword(microword),
    .ad(ad),
    .pcFlags(pcFlags),
    .testSatisfied(testSatisfied),
    .loadVmaContext(loadVmaContext),
    .loadHeld(loadHeld),
    .condSelVma(condSelVma),
    .diagWrite(diagWrite),
    .diagRegAddr(diagRegAddr),
    .diagData(diagData),
    .cycle(cycle),
    .fetch(fetch),
    .storeAr(storeAr),
    .mboxReq(mboxReq),
    .vmaCtx(vmaCtx),
    .addrErr(addrErr),
    .heldOrPc(heldOrPc),
    .diagBus(diagBus)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    edgeCount <= edgeCount + 1;
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h80200003;
    end else begin
      return state >> 1;
    end
  endfunction

  // Filler for AD bits that the row does not look at
  function automatic logic [12:0] randomAd();
    logic [12:0] value;
    for (int i = 0; i < 13; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value[i] = lfsrState[0];
    end
    return value;
  endfunction

  // Returns one step after the next rising edge
  task automatic waitEdge();
    int start;
    int waited;
    start = edgeCount;
    waited = 0;
    while (edgeCount == start && waited < edgeTimeout) begin
      #1;
      waited++;
    end
    if (edgeCount == start) begin
      timedOut = 1'b1;
    end
  endtask

  task automatic applyRow(input vecT v);
    microword.memFunc = mclPkg::memFuncE'(v.memFunc);
    microword.magic = v.magic;
    ad = v.ctl[1] ? randomAd() : v.ad;
    testSatisfied = v.ctl[0];
    pcFlags = v.pcFlags;
    {loadVmaContext, loadHeld, condSelVma, diagWrite} = v.strobes;
    diagRegAddr = v.diagRegAddr;
    diagData = v.diagData;
  endtask

  task automatic checkField(input string name, input logic [12:0] expValue,
                            input logic [12:0] gotValue);
    assert (gotValue === expValue) else begin
      $display("FAILED %s expected %h got %h", name, expValue, gotValue);
      rowErrors++;
    end
  endtask

  initial begin
    reset = 1'b1;
    microword = '0;
    ad = '0;
    pcFlags = '0;
    testSatisfied = 1'b0;
    loadVmaContext = 1'b0;
    loadHeld = 1'b0;
    condSelVma = 1'b0;
    diagWrite = 1'b0;
    diagRegAddr = 4'h0;
    diagData = 5'h00;
    for (int i = 0; i < 5 && !timedOut; i++) begin
      waitEdge();
    end
    reset = 1'b0;
    for (int r = 0; r < numVecs && !timedOut; r++) begin
      applyRow(vectors[r]);
      waitEdge();
      if (!timedOut) begin
        rowErrors = 0;
        checkField("cycle", {9'h0, vectors[r].expCycle}, {9'h0, cycle});
        checkField("fetch", {12'h0, vectors[r].expBits[2]}, {12'h0, fetch});
        checkField("storeAr", {12'h0, vectors[r].expBits[1]}, {12'h0, storeAr});
        checkField("mboxReq", {12'h0, vectors[r].expBits[0]}, {12'h0, mboxReq});
        checkField("vmaCtx", {9'h0, vectors[r].expCtx}, {9'h0, vmaCtx});
        checkField("addrErr", {12'h0, vectors[r].expAddrErr}, {12'h0, addrErr});
        checkField("heldOrPc", {1'b0, vectors[r].expHeld}, {1'b0, heldOrPc});
        checkField("diagBus", {7'h0, vectors[r].expDiag}, {7'h0, diagBus});
        if (rowErrors == 0) begin
          passCount++;
          $display("test %0d ok", r);
        end else begin
          failCount++;
          $display("test %0d failed with %0d wrong values", r, rowErrors);
        end
      end
    end
    if (timedOut) begin
      $display("Run stopped because no clock edge arrived in time");
    end
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (failCount == 0 && !timedOut) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== mcl.f ====
+incdir+verification
common/mclPkg.sv
hw/memFuncDecode.sv
cycleCtl/memCycleCtl.sv
vmaContext/vmaContext.sv
hw/diagRegs.sv
hw/diagReadback.sv
hw/mcl.sv
verification/mclTb.sv

// ==== runSim.sh ====
#!/bin/bash
# Build and run the mcl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mclTb -f mcl.f -o mclSim \
  > build.log 2>&1 &&
  ./obj_dir/mclSim > sim.log 2>&1 ||
  { echo "Build or simulation run failed"; cat build.log sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "=== PASS ===" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
